/* verilog/rename_consts.svh */
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// architectural register file
`define RC_NUM_REGS   32
`define RC_REG_IDX_W  5

// datapath width
`define RC_DATA_W     32

// reorder buffer entries
`define RC_ROB_DEPTH  8

// tags run 1 to RC_ROB_DEPTH, 0 means no pending writer
`define RC_TAG_W      4

`endif

/* verilog/core_types_pkg.sv */
`default_nettype none

`include "rename_consts.svh"

package core_types_pkg;

    // data value
    typedef logic [`RC_DATA_W-1:0] word_t;

    // architectural register index, x0 reads zero
    typedef logic [`RC_REG_IDX_W-1:0] reg_idx_t;

    // reorder buffer tag, zero is no pending writer
    typedef logic [`RC_TAG_W-1:0] rob_tag_t;

endpackage

`default_nettype wire

/* verilog/rename_if_pkg.sv */
`default_nettype none

package rename_if_pkg;

    // instruction offered at dispatch
    typedef struct packed {
        core_types_pkg::reg_idx_t rs1;
        core_types_pkg::reg_idx_t rs2;
        core_types_pkg::reg_idx_t rd;
        logic                     has_rd;
    } issue_t;

    // value only meaningful when tag is zero
    typedef struct packed {
        core_types_pkg::rob_tag_t tag;
        core_types_pkg::word_t    value;
    } operand_t;

    typedef struct packed {
        operand_t                 src1;
        operand_t                 src2;
        core_types_pkg::rob_tag_t dest_tag;
    } dispatch_t;

    // rename request
    typedef struct packed {
        core_types_pkg::reg_idx_t rd;
        logic                     has_rd;
        core_types_pkg::rob_tag_t tag;
    } alloc_t;

    typedef struct packed {
        core_types_pkg::rob_tag_t tag;
        core_types_pkg::word_t    value;
        logic                     mispredict;
    } wb_t;

    typedef struct packed {
        core_types_pkg::reg_idx_t rd;
        logic                     has_rd;
        core_types_pkg::rob_tag_t tag;
        core_types_pkg::word_t    value;
        logic                     flush;
    } commit_t;

endpackage

`default_nettype wire

/* verilog/reg_status.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_consts.svh"

module reg_status (
    input  logic                     clk,
    input  logic                     rst,

    // operand reads from dispatch
    input  core_types_pkg::reg_idx_t rs1,
    input  core_types_pkg::reg_idx_t rs2,
    output rename_if_pkg::operand_t  src1,
    output rename_if_pkg::operand_t  src2,

    // rename of the destination
    input  logic                     alloc_valid,
    input  rename_if_pkg::alloc_t    alloc,

    // in-order commit from the reorder buffer
    input  logic                     commit_valid,
    input  rename_if_pkg::commit_t   commit
);

    core_types_pkg::word_t    val_q  [`RC_NUM_REGS];
    core_types_pkg::rob_tag_t tag_q  [`RC_NUM_REGS];

    // table after flush and commit of this cycle
    core_types_pkg::word_t    val_rd [`RC_NUM_REGS];
    core_types_pkg::rob_tag_t tag_rd [`RC_NUM_REGS];

    // next tags, rename applied on top
    core_types_pkg::rob_tag_t tag_d  [`RC_NUM_REGS];

    logic flush;
    logic commit_wr;
    logic rename_wr;

    assign flush     = commit_valid && commit.flush;
    assign commit_wr = commit_valid && commit.has_rd && (commit.rd != '0);
    assign rename_wr = alloc_valid && alloc.has_rd && (alloc.rd != '0);

    always_comb begin
        for (int i = 0; i < `RC_NUM_REGS; i++) begin
            tag_rd[i] = flush ? '0 : tag_q[i];
            val_rd[i] = val_q[i];
        end
        if (commit_wr) begin
            val_rd[commit.rd] = commit.value;
            // only the newest writer clears the pending tag
            if (tag_rd[commit.rd] == commit.tag) begin
                tag_rd[commit.rd] = '0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RC_NUM_REGS; i++) begin
            tag_d[i] = tag_rd[i];
        end
        if (rename_wr) begin
            tag_d[alloc.rd] = alloc.tag;
        end
    end

    // the rename in this cycle belongs to the instruction being read,
    // so its sources see the table before its own destination
    assign src1 = '{tag: tag_rd[rs1], value: val_rd[rs1]};
    assign src2 = '{tag: tag_rd[rs2], value: val_rd[rs2]};

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_q <= '{default: '0};
            val_q <= '{default: '0};
        end else begin
            tag_q <= tag_d;
            val_q <= val_rd;
        end
    end

    a_reg0_no_tag: assert property (
        @(posedge clk) disable iff (rst)
        tag_q[0] == '0
    );

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_consts.svh"

module reorder_buffer (
    input  logic                     clk,
    input  logic                     rst,

    // allocation at the tail
    input  logic                     alloc_valid,
    input  rename_if_pkg::alloc_t    alloc,
    output logic                     alloc_ready,
    output core_types_pkg::rob_tag_t next_tag,

    // result writeback by tag
    input  logic                     wb_valid,
    input  rename_if_pkg::wb_t       wb,

    // one commit per cycle from the head
    output logic                     commit_valid,
    output rename_if_pkg::commit_t   commit
);

    localparam int DEPTH = `RC_ROB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    typedef struct packed {
        core_types_pkg::reg_idx_t rd;
        logic                     has_rd;
        core_types_pkg::word_t    value;
        logic                     mispredict;
    } entry_t;

    entry_t             ent [DEPTH];
    logic [DEPTH-1:0]   busy;
    logic [DEPTH-1:0]   done;
    ptr_t               head;
    ptr_t               tail;
    logic [CNT_W-1:0]   count;

    logic flush;
    logic alloc_fire;
    logic commit_fire;
    ptr_t wb_idx;

    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_inc = (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // flushing commit is on the output this cycle
    assign flush = commit_valid && commit.flush;

    assign alloc_ready = (count != CNT_W'(DEPTH)) && !flush;
    assign next_tag    = core_types_pkg::rob_tag_t'(tail) + 1'b1;
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign commit_fire = busy[head] && done[head] && !flush;
    assign wb_idx      = ptr_t'(wb.tag - 1'b1);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            busy         <= '0;
            done         <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (alloc_fire) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= ptr_inc(tail);
            end
            if (wb_valid) begin
                done[wb_idx] <= 1'b1;
            end
            if (commit_fire) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= ptr_inc(head);
            end
            count        <= count + CNT_W'(alloc_fire) - CNT_W'(commit_fire);
            commit_valid <= commit_fire;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            ent[tail].rd     <= alloc.rd;
            ent[tail].has_rd <= alloc.has_rd;
        end
        if (wb_valid) begin
            ent[wb_idx].value      <= wb.value;
            ent[wb_idx].mispredict <= wb.mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_fire) begin
            commit.rd     <= ent[head].rd;
            commit.has_rd <= ent[head].has_rd;
            commit.tag    <= core_types_pkg::rob_tag_t'(head) + 1'b1;
            commit.value  <= ent[head].value;
            commit.flush  <= ent[head].mispredict;
        end
    end

    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (rst)
        alloc_valid |-> count != CNT_W'(DEPTH)
    );

    a_wb_live: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid |-> busy[wb_idx] && !done[wb_idx]
    );

endmodule

`default_nettype wire

/* verilog/dispatch_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch_ctrl (
    input  logic                     clk,
    input  logic                     rst,

    // external four-phase port
    input  logic                     dispatch_req,
    input  rename_if_pkg::issue_t    issue_in,
    output logic                     dispatch_ack,
    output rename_if_pkg::dispatch_t dispatch_out,

    // operand reads
    output core_types_pkg::reg_idx_t rs1,
    output core_types_pkg::reg_idx_t rs2,
    input  rename_if_pkg::operand_t  src1,
    input  rename_if_pkg::operand_t  src2,

    // allocation
    input  logic                     alloc_ready,
    input  core_types_pkg::rob_tag_t next_tag,
    output logic                     alloc_valid,
    output rename_if_pkg::alloc_t    alloc
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ready,
        st_ack_high
    } state_t;

    state_t state;
    state_t state_d;
    logic   grant;

    assign grant = dispatch_req && alloc_ready && (state != st_ack_high);

    always_comb begin
        state_d = state;
        case (state)
            st_idle: begin
                if (dispatch_req) begin
                    state_d = alloc_ready ? st_ack_high : st_wait_ready;
                end
            end
            st_wait_ready: begin
                if (!dispatch_req) begin
                    state_d = st_idle;
                end else if (alloc_ready) begin
                    state_d = st_ack_high;
                end
            end
            st_ack_high: begin
                if (!dispatch_req) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_d;
        end
    end

    assign dispatch_ack = (state == st_ack_high);

    // held stable while ack is high
    always_ff @(posedge clk) begin
        if (grant) begin
            dispatch_out <= '{src1: src1, src2: src2, dest_tag: next_tag};
        end
    end

    assign rs1 = issue_in.rs1;
    assign rs2 = issue_in.rs2;

    // x0 destination takes an entry but is not renamed
    assign alloc_valid  = grant;
    assign alloc.rd     = issue_in.rd;
    assign alloc.has_rd = issue_in.has_rd && (issue_in.rd != '0);
    assign alloc.tag    = next_tag;

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(dispatch_ack) |-> $past(dispatch_req)
    );

endmodule

`default_nettype wire

/* verilog/rename_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_core (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     dispatch_req,
    input  rename_if_pkg::issue_t    issue_in,
    output logic                     dispatch_ack,
    output rename_if_pkg::dispatch_t dispatch_out,

    input  logic                     wb_valid,
    input  rename_if_pkg::wb_t       wb,

    output logic                     commit_valid,
    output rename_if_pkg::commit_t   commit
);

    core_types_pkg::reg_idx_t rs1;
    core_types_pkg::reg_idx_t rs2;
    rename_if_pkg::operand_t  src1;
    rename_if_pkg::operand_t  src2;
    logic                     alloc_valid;
    rename_if_pkg::alloc_t    alloc;
    logic                     alloc_ready;
    core_types_pkg::rob_tag_t next_tag;

    reg_status i_reg_status (
        .clk          (clk),
        .rst          (rst),
        .rs1          (rs1),
        .rs2          (rs2),
        .src1         (src1),
        .src2         (src2),
        .alloc_valid  (alloc_valid),
        .alloc        (alloc),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    reorder_buffer i_rob (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc        (alloc),
        .alloc_ready  (alloc_ready),
        .next_tag     (next_tag),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    dispatch_ctrl i_dispatch (
        .clk          (clk),
        .rst          (rst),
        .dispatch_req (dispatch_req),
        .issue_in     (issue_in),
        .dispatch_ack (dispatch_ack),
        .dispatch_out (dispatch_out),
        .rs1          (rs1),
        .rs2          (rs2),
        .src1         (src1),
        .src2         (src2),
        .alloc_ready  (alloc_ready),
        .next_tag     (next_tag),
        .alloc_valid  (alloc_valid),
        .alloc        (alloc)
    );

endmodule

`default_nettype wire

/* tests/rename_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_core_tb;

    localparam int CYCLES_PER_LINE = 50;

    logic                     clk;
    logic                     rst;
    logic                     dispatch_req;
    rename_if_pkg::issue_t    issue_in;
    logic                     dispatch_ack;
    rename_if_pkg::dispatch_t dispatch_out;
    logic                     wb_valid;
    rename_if_pkg::wb_t       wb;
    logic                     commit_valid;
    rename_if_pkg::commit_t   commit;

    rename_if_pkg::commit_t   commit_q [$];
    string                    lines [$];
    int                       timeout_cycles = 0;
    logic                     dispatch_pending = 1'b0;

    rename_core i_dut (
        .clk          (clk),
        .rst          (rst),
        .dispatch_req (dispatch_req),
        .issue_in     (issue_in),
        .dispatch_ack (dispatch_ack),
        .dispatch_out (dispatch_out),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #5 clk = ~clk;

    // commit pulses are sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            commit_q.push_back(commit);
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_operand(input string name, input rename_if_pkg::operand_t exp,
                                 input rename_if_pkg::operand_t act);
        // value is only defined for a ready operand
        if (exp.tag != act.tag || (exp.tag == '0 && exp.value != act.value)) begin
            fail_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input core_types_pkg::rob_tag_t exp,
                             input core_types_pkg::rob_tag_t act);
        if (exp != act) begin
            fail_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_commit(input string name, input rename_if_pkg::commit_t exp,
                                input rename_if_pkg::commit_t act);
        if (exp != act) begin
            fail_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic finish_dispatch(input string name, input rename_if_pkg::dispatch_t exp);
        do @(negedge clk); while (!dispatch_ack);
        check_operand({name, " src1"}, exp.src1, dispatch_out.src1);
        check_operand({name, " src2"}, exp.src2, dispatch_out.src2);
        check_tag({name, " dest_tag"}, exp.dest_tag, dispatch_out.dest_tag);
        idle_gap();
        @(posedge clk);
        dispatch_req <= 1'b0;
        do @(negedge clk); while (dispatch_ack);
        dispatch_pending = 1'b0;
    endtask

    task automatic run_dispatch(input string name, input rename_if_pkg::issue_t ins,
                                input rename_if_pkg::dispatch_t exp, input logic stall);
        idle_gap();
        @(posedge clk);
        dispatch_req <= 1'b1;
        issue_in     <= ins;
        dispatch_pending = 1'b1;
        if (stall) begin
            // full buffer, ack must wait for a commit
            repeat (4) begin
                @(negedge clk);
                if (dispatch_ack) begin
                    fail_run({name, ": ack rose while the reorder buffer was full"});
                end
            end
            fork
                finish_dispatch(name, exp);
            join_none
        end else begin
            finish_dispatch(name, exp);
        end
    endtask

    task automatic drive_writeback(input rename_if_pkg::wb_t w);
        idle_gap();
        @(posedge clk);
        wb_valid <= 1'b1;
        wb       <= w;
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    task automatic expect_commit(input string name, input rename_if_pkg::commit_t exp);
        rename_if_pkg::commit_t act;
        while (commit_q.size() == 0) begin
            @(negedge clk);
        end
        act = commit_q.pop_front();
        check_commit(name, exp, act);
    endtask

    task automatic load_lines();
        int    fd;
        string line;
        fd = $fopen("tests/rename_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tests/rename_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_line(input string line);
        string                    name;
        string                    body;
        logic [31:0]              f [10];
        int                       n;
        rename_if_pkg::issue_t    ins;
        rename_if_pkg::dispatch_t exp_d;
        rename_if_pkg::wb_t       w;
        rename_if_pkg::commit_t   exp_c;
        body = line.substr(1, line.len() - 1);
        case (line.getc(0))
            "D": begin
                n = $sscanf(body, "%h %h %h %h %h %h %h %h %h %h %s", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9], name);
                if (n != 11) begin
                    fail_run({"malformed dispatch line: ", line});
                end
                ins.rs1              = core_types_pkg::reg_idx_t'(f[1]);
                ins.rs2              = core_types_pkg::reg_idx_t'(f[2]);
                ins.rd               = core_types_pkg::reg_idx_t'(f[3]);
                ins.has_rd           = f[4][0];
                exp_d.src1.tag       = core_types_pkg::rob_tag_t'(f[5]);
                exp_d.src1.value     = core_types_pkg::word_t'(f[6]);
                exp_d.src2.tag       = core_types_pkg::rob_tag_t'(f[7]);
                exp_d.src2.value     = core_types_pkg::word_t'(f[8]);
                exp_d.dest_tag       = core_types_pkg::rob_tag_t'(f[9]);
                wait (!dispatch_pending);
                run_dispatch(name, ins, exp_d, f[0][0]);
            end
            "W": begin
                n = $sscanf(body, "%h %h %h %s", f[0], f[1], f[2], name);
                if (n != 4) begin
                    fail_run({"malformed writeback line: ", line});
                end
                w.tag        = core_types_pkg::rob_tag_t'(f[0]);
                w.value      = core_types_pkg::word_t'(f[1]);
                w.mispredict = f[2][0];
                drive_writeback(w);
            end
            "C": begin
                n = $sscanf(body, "%h %h %h %h %h %s", f[0], f[1], f[2], f[3], f[4], name);
                if (n != 6) begin
                    fail_run({"malformed commit line: ", line});
                end
                exp_c.rd     = core_types_pkg::reg_idx_t'(f[0]);
                exp_c.has_rd = f[1][0];
                exp_c.tag    = core_types_pkg::rob_tag_t'(f[2]);
                exp_c.value  = core_types_pkg::word_t'(f[3]);
                exp_c.flush  = f[4][0];
                expect_commit(name, exp_c);
            end
            default: begin
                fail_run({"unknown kind of test data line: ", line});
            end
        endcase
    endtask

    initial begin : watchdog
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        fail_run($sformatf("Timeout: run did not finish within %0d cycles", timeout_cycles));
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        dispatch_req = 1'b0;
        issue_in     = '0;
        wb_valid     = 1'b0;
        wb           = '0;
        void'($urandom(32'h4732));
        load_lines();
        timeout_cycles = lines.size() * CYCLES_PER_LINE;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        wait (!dispatch_pending);
        repeat (4) @(negedge clk);
        if (commit_q.size() != 0) begin
            fail_run($sformatf("%0d commits arrived that the test data did not expect",
                               commit_q.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/rename_testdata.txt */
# D stall rs1 rs2 rd has_rd src1_tag src1_val src2_tag src2_val dest_tag name
# W tag value mispredict name, C rd has_rd tag value flush name (all hex)
D 0 01 02 03 1 0 00000000 0 00000000 1 reset_read
D 0 03 00 03 1 1 00000000 0 00000000 2 pending_tag
D 0 03 03 05 1 2 00000000 2 00000000 3 newest_tag
D 0 00 05 00 1 0 00000000 3 00000000 4 x0_dest
D 0 00 00 04 1 0 00000000 0 00000000 5 x0_read
W 3 33333333 0 wb_out_of_order
W 1 11111111 0 wb_head
C 03 1 1 11111111 0 commit_first
D 0 03 01 06 1 2 00000000 0 00000000 6 younger_pending
W 2 22222222 0 wb_second
C 03 1 2 22222222 0 commit_second
C 05 1 3 33333333 0 commit_held
D 0 03 05 07 1 0 22222222 0 33333333 7 read_committed
W 4 44444444 0 wb_x0
C 00 0 4 44444444 0 commit_x0
W 5 55555555 0 wb_fifth
C 04 1 5 55555555 0 commit_fifth
D 0 04 00 08 1 0 55555555 0 00000000 8 read_after_x0
D 0 08 06 09 1 8 00000000 6 00000000 1 tag_wrap
D 0 09 00 0a 1 1 00000000 0 00000000 2 fill_2
D 0 00 00 0b 1 0 00000000 0 00000000 3 fill_3
D 0 00 00 0c 1 0 00000000 0 00000000 4 fill_4
D 0 00 00 0d 1 0 00000000 0 00000000 5 fill_5
D 1 0d 00 0e 1 5 00000000 0 00000000 6 full_stall
W 6 66666666 0 wb_free_head
C 06 1 6 66666666 0 commit_free_head
W 7 77777777 1 wb_mispredict
C 07 1 7 77777777 1 commit_flush
D 0 07 06 03 1 0 77777777 0 66666666 1 flush_read
D 0 08 0e 00 0 0 00000000 0 00000000 2 flush_clear
D 0 05 04 00 0 0 33333333 0 55555555 3 flush_values

/* project.f */
+incdir+verilog
verilog/core_types_pkg.sv
verilog/rename_if_pkg.sv
verilog/reg_status.sv
verilog/reorder_buffer.sv
verilog/dispatch_ctrl.sv
verilog/rename_core.sv
tests/rename_core_tb.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_types_pkg.sv
      - verilog/rename_if_pkg.sv
      - verilog/reg_status.sv
      - verilog/reorder_buffer.sv
      - verilog/dispatch_ctrl.sv
      - verilog/rename_core.sv
  - target: test
    files:
      - tests/rename_core_tb.sv
